/* Bender.yml */
package:
  name: control_unit

sources:
  - include_dirs:
      - logic
    files:
      - logic/isa_pkg.sv
      - logic/core_pkg.sv
      - logic/instr_decoder.sv
      - logic/alu.sv
      - logic/regfile.sv
      - logic/writeback_stage.sv
      - logic/control_unit.sv
  - target: simulation
    files:
      - sim/control_unit_tb.sv

/* logic/alu.sv */
`timescale 1ns/1ps

`include "core_cfg.svh"

module alu (
    input  core_pkg::alu_op_e     alu_op,
    input  core_pkg::word_t       rs_data,
    input  core_pkg::word_t       rt_data,
    input  core_pkg::reg_idx_t    sh_amount,
    input  logic [`CORE_IMM_W-1:0] imm,
    input  logic                  use_imm,
    input  logic                  imm_sign,
    input  logic                  shift_by_rs,
    output core_pkg::word_t       result
);

    localparam int EXT_W = `CORE_XLEN - `CORE_IMM_W;

    core_pkg::word_t    imm_ext;
    core_pkg::word_t    op_b;
    core_pkg::reg_idx_t shamt;
    logic               lt_signed;

    // sign or zero extension of the immediate
    assign imm_ext = imm_sign ? {{EXT_W{imm[`CORE_IMM_W-1]}}, imm} : {{EXT_W{1'b0}}, imm};

    // second operand, register or immediate
    assign op_b = use_imm ? imm_ext : rt_data;

    // shift amount from the shamt field or low bits of rs
    assign shamt = shift_by_rs ? rs_data[`CORE_REG_AW-1:0] : sh_amount;

    // signed compare for slt
    assign lt_signed = $signed(rs_data) < $signed(op_b);

    always_comb begin
        case (alu_op)
            core_pkg::ALU_ADD: result = rs_data + op_b;
            core_pkg::ALU_SUB: result = rs_data - op_b;
            core_pkg::ALU_AND: result = rs_data & op_b;
            core_pkg::ALU_OR:  result = rs_data | op_b;
            core_pkg::ALU_XOR: result = rs_data ^ op_b;
            core_pkg::ALU_NOR: result = ~(rs_data | op_b);
            // shifted value is always rt
            core_pkg::ALU_SLL: result = rt_data << shamt;
            core_pkg::ALU_SRL: result = rt_data >> shamt;
            // arithmetic fill from the sign bit
            core_pkg::ALU_SRA: result = $signed(rt_data) >>> shamt;
            core_pkg::ALU_SLT: result = {{(`CORE_XLEN-1){1'b0}}, lt_signed};
            // low word of the product only
            core_pkg::ALU_MUL: result = rs_data * op_b;
            core_pkg::ALU_DIV: begin
                // unsigned quotient, all ones on divide by zero
                if (op_b == '0) begin
                    result = '1;
                end else begin
                    result = rs_data / op_b;
                end
            end
            core_pkg::ALU_LUI: result = {imm, {EXT_W{1'b0}}};
            default:           result = '0;
        endcase
    end

endmodule

/* logic/control_unit.sv */
`timescale 1ns/1ps

`include "core_cfg.svh"

module control_unit (
    input  logic                   clk,
    input  logic                   rst_b,
    input  isa_pkg::opcode_e       opcode,
    input  isa_pkg::func_e         func,
    input  core_pkg::reg_idx_t     rs_num,
    input  core_pkg::reg_idx_t     rt_num,
    input  core_pkg::reg_idx_t     rd_num,
    input  core_pkg::reg_idx_t     sh_amount,
    input  logic [`CORE_IMM_W-1:0] imm,
    output logic                   commit_valid,
    output core_pkg::reg_idx_t     commit_num,
    output core_pkg::word_t        commit_data,
    output logic                   halted
);

    // decoder outputs
    core_pkg::alu_op_e  alu_op;
    logic               use_imm;
    logic               imm_sign;
    logic               shift_by_rs;
    logic               wr_req;
    core_pkg::reg_idx_t wr_num;
    logic               halt_req;

    // datapath
    core_pkg::word_t    rs_data;
    core_pkg::word_t    rt_data;
    core_pkg::word_t    result;

    // register file write port
    logic               rf_we;
    core_pkg::reg_idx_t rf_num;
    core_pkg::word_t    rf_data;

    instr_decoder instr_decoder_i (
        .opcode      (opcode),
        .func        (func),
        .rt_num      (rt_num),
        .rd_num      (rd_num),
        .alu_op      (alu_op),
        .use_imm     (use_imm),
        .imm_sign    (imm_sign),
        .shift_by_rs (shift_by_rs),
        .wr_req      (wr_req),
        .wr_num      (wr_num),
        .halt_req    (halt_req)
    );

    // operands read straight from the instruction fields
    regfile regfile_i (
        .clk     (clk),
        .rst_b   (rst_b),
        .rs_num  (rs_num),
        .rt_num  (rt_num),
        .rf_we   (rf_we),
        .rf_num  (rf_num),
        .rf_data (rf_data),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    alu alu_i (
        .alu_op      (alu_op),
        .rs_data     (rs_data),
        .rt_data     (rt_data),
        .sh_amount   (sh_amount),
        .imm         (imm),
        .use_imm     (use_imm),
        .imm_sign    (imm_sign),
        .shift_by_rs (shift_by_rs),
        .result      (result)
    );

    // write gating and commit trace
    writeback_stage writeback_stage_i (
        .clk          (clk),
        .rst_b        (rst_b),
        .wr_req       (wr_req),
        .wr_num       (wr_num),
        .result       (result),
        .halt_req     (halt_req),
        .rf_we        (rf_we),
        .rf_num       (rf_num),
        .rf_data      (rf_data),
        .commit_valid (commit_valid),
        .commit_num   (commit_num),
        .commit_data  (commit_data),
        .halted       (halted)
    );

endmodule

/* logic/core_cfg.svh */
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// data word width
`define CORE_XLEN      32

// register index width, enough for 32 entries
`define CORE_REG_AW    5

// register file depth
`define CORE_NUM_REGS  32

// immediate field of I-type instructions
`define CORE_IMM_W     16

// opcode and function fields share one width
`define CORE_OPC_W     6

`endif

/* logic/core_pkg.sv */
`include "core_cfg.svh"

package core_pkg;

    // width of the internal ALU operation code
    localparam int ALU_OP_W = 5;

    // one data word
    typedef logic [`CORE_XLEN-1:0] word_t;

    // register number
    typedef logic [`CORE_REG_AW-1:0] reg_idx_t;

    // internal ALU operations
    // signed and unsigned add share one op, no overflow trap
    typedef enum logic [ALU_OP_W-1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_MUL,
        ALU_DIV,
        ALU_LUI
    } alu_op_e;

endpackage

/* logic/instr_decoder.sv */
`timescale 1ns/1ps

module instr_decoder (
    input  isa_pkg::opcode_e   opcode,
    input  isa_pkg::func_e     func,
    input  core_pkg::reg_idx_t rt_num,
    input  core_pkg::reg_idx_t rd_num,
    output core_pkg::alu_op_e  alu_op,
    output logic               use_imm,
    output logic               imm_sign,
    output logic               shift_by_rs,
    output logic               wr_req,
    output core_pkg::reg_idx_t wr_num,
    output logic               halt_req
);

    always_comb begin
        // defaults describe a harmless R-type add with no write
        alu_op      = core_pkg::ALU_ADD;
        use_imm     = 1'b0;
        imm_sign    = 1'b0;
        shift_by_rs = 1'b0;
        wr_req      = 1'b0;
        wr_num      = rd_num;
        halt_req    = 1'b0;

        case (opcode)
            isa_pkg::OPC_RTYPE: begin
                // R-type writes rd
                wr_num = rd_num;
                wr_req = 1'b1;
                case (func)
                    isa_pkg::FN_ADD,
                    isa_pkg::FN_ADDU: begin
                        alu_op = core_pkg::ALU_ADD;
                    end
                    isa_pkg::FN_SUB,
                    isa_pkg::FN_SUBU: begin
                        alu_op = core_pkg::ALU_SUB;
                    end
                    isa_pkg::FN_AND: begin
                        alu_op = core_pkg::ALU_AND;
                    end
                    isa_pkg::FN_OR: begin
                        alu_op = core_pkg::ALU_OR;
                    end
                    isa_pkg::FN_XOR: begin
                        alu_op = core_pkg::ALU_XOR;
                    end
                    isa_pkg::FN_NOR: begin
                        alu_op = core_pkg::ALU_NOR;
                    end
                    isa_pkg::FN_SLL: begin
                        alu_op = core_pkg::ALU_SLL;
                    end
                    isa_pkg::FN_SRL: begin
                        alu_op = core_pkg::ALU_SRL;
                    end
                    isa_pkg::FN_SRA: begin
                        alu_op = core_pkg::ALU_SRA;
                    end
                    isa_pkg::FN_SLLV: begin
                        // amount taken from rs
                        alu_op      = core_pkg::ALU_SLL;
                        shift_by_rs = 1'b1;
                    end
                    isa_pkg::FN_SRLV: begin
                        alu_op      = core_pkg::ALU_SRL;
                        shift_by_rs = 1'b1;
                    end
                    isa_pkg::FN_SLT: begin
                        alu_op = core_pkg::ALU_SLT;
                    end
                    isa_pkg::FN_MULT: begin
                        alu_op = core_pkg::ALU_MUL;
                    end
                    isa_pkg::FN_DIV: begin
                        alu_op = core_pkg::ALU_DIV;
                    end
                    default: begin
                        // syscall and unknown functions both stop the core
                        wr_req   = 1'b0;
                        halt_req = 1'b1;
                    end
                endcase
            end
            isa_pkg::OPC_ADDI,
            isa_pkg::OPC_ADDIU: begin
                // sign-extended immediate, result to rt
                alu_op   = core_pkg::ALU_ADD;
                use_imm  = 1'b1;
                imm_sign = 1'b1;
                wr_num   = rt_num;
                wr_req   = 1'b1;
            end
            isa_pkg::OPC_ANDI: begin
                // zero-extended immediate
                alu_op  = core_pkg::ALU_AND;
                use_imm = 1'b1;
                wr_num  = rt_num;
                wr_req  = 1'b1;
            end
            isa_pkg::OPC_XORI: begin
                alu_op  = core_pkg::ALU_XOR;
                use_imm = 1'b1;
                wr_num  = rt_num;
                wr_req  = 1'b1;
            end
            isa_pkg::OPC_LUI: begin
                // immediate goes to the upper half
                alu_op  = core_pkg::ALU_LUI;
                use_imm = 1'b1;
                wr_num  = rt_num;
                wr_req  = 1'b1;
            end
            default: begin
                // unknown opcode
                halt_req = 1'b1;
            end
        endcase
    end

endmodule

/* logic/isa_pkg.sv */
`include "core_cfg.svh"

package isa_pkg;

    // instruction field widths
    localparam int OPC_W  = `CORE_OPC_W;
    localparam int FUNC_W = `CORE_OPC_W;

    // major opcode, standard MIPS encodings
    // only the kept subset is listed
    typedef enum logic [OPC_W-1:0] {
        OPC_RTYPE = 6'b000000,
        OPC_ADDI  = 6'b001000,
        OPC_ADDIU = 6'b001001,
        OPC_ANDI  = 6'b001100,
        OPC_XORI  = 6'b001110,
        OPC_LUI   = 6'b001111
    } opcode_e;

    // function code of R-type instructions
    typedef enum logic [FUNC_W-1:0] {
        // shifts by shamt field
        FN_SLL     = 6'b000000,
        FN_SRL     = 6'b000010,
        FN_SRA     = 6'b000011,
        // shifts by rs
        FN_SLLV    = 6'b000100,
        FN_SRLV    = 6'b000110,
        // stops the core
        FN_SYSCALL = 6'b001100,
        // multiply and divide write rd directly here
        FN_MULT    = 6'b011000,
        FN_DIV     = 6'b011010,
        // arithmetic
        FN_ADD     = 6'b100000,
        FN_ADDU    = 6'b100001,
        FN_SUB     = 6'b100010,
        FN_SUBU    = 6'b100011,
        // logic
        FN_AND     = 6'b100100,
        FN_OR      = 6'b100101,
        FN_XOR     = 6'b100110,
        FN_NOR     = 6'b100111,
        // signed compare
        FN_SLT     = 6'b101010
    } func_e;

endpackage

/* logic/regfile.sv */
`timescale 1ns/1ps

`include "core_cfg.svh"

module regfile (
    input  logic               clk,
    input  logic               rst_b,
    input  core_pkg::reg_idx_t rs_num,
    input  core_pkg::reg_idx_t rt_num,
    input  logic               rf_we,
    input  core_pkg::reg_idx_t rf_num,
    input  core_pkg::word_t    rf_data,
    output core_pkg::word_t    rs_data,
    output core_pkg::word_t    rt_data
);

    // register array
    core_pkg::word_t regs [`CORE_NUM_REGS];

    // single write port
    always_ff @(posedge clk) begin
        if (!rst_b) begin
            // every register starts at zero
            for (int i = 0; i < `CORE_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (rf_we) begin
            regs[rf_num] <= rf_data;
        end
    end

    // two read ports, combinational
    // register 0 is hardwired to zero
    always_comb begin
        if (rs_num == '0) begin
            rs_data = '0;
        end else begin
            rs_data = regs[rs_num];
        end

        if (rt_num == '0) begin
            rt_data = '0;
        end else begin
            rt_data = regs[rt_num];
        end
    end

endmodule

/* logic/writeback_stage.sv */
`timescale 1ns/1ps

module writeback_stage (
    input  logic               clk,
    input  logic               rst_b,
    input  logic               wr_req,
    input  core_pkg::reg_idx_t wr_num,
    input  core_pkg::word_t    result,
    input  logic               halt_req,
    output logic               rf_we,
    output core_pkg::reg_idx_t rf_num,
    output core_pkg::word_t    rf_data,
    output logic               commit_valid,
    output core_pkg::reg_idx_t commit_num,
    output core_pkg::word_t    commit_data,
    output logic               halted
);

    // write enable, blocked once halted and for register 0
    assign rf_we   = wr_req && !halted && (wr_num != '0);
    assign rf_num  = wr_num;
    assign rf_data = result;

    // sticky halt flag and commit strobe
    always_ff @(posedge clk) begin
        if (!rst_b) begin
            halted       <= 1'b0;
            commit_valid <= 1'b0;
        end else begin
            halted       <= halted | halt_req;
            commit_valid <= rf_we;
        end
    end

    // commit payload, holds the last write
    always_ff @(posedge clk) begin
        if (rf_we) begin
            commit_num  <= rf_num;
            commit_data <= rf_data;
        end
    end

endmodule

/* project.f */
+incdir+logic
logic/isa_pkg.sv
logic/core_pkg.sv
logic/instr_decoder.sv
logic/alu.sv
logic/regfile.sv
logic/writeback_stage.sv
logic/control_unit.sv
sim/control_unit_tb.sv

/* sim/control_unit_tb.sv */
`timescale 1ns/1ps

module control_unit_tb;

    // one table entry with the reset flag, instruction fields and expectations
    typedef struct packed {
        logic        rst;
        logic [5:0]  opc;
        logic [5:0]  fn;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  sh;
        logic [15:0] imm;
        logic        exp_valid;
        logic [4:0]  exp_num;
        logic [31:0] exp_data;
        logic        exp_halted;
    } row_t;

    logic               clk;
    logic               rst_b;
    isa_pkg::opcode_e   opcode;
    isa_pkg::func_e     func;
    core_pkg::reg_idx_t rs_num;
    core_pkg::reg_idx_t rt_num;
    core_pkg::reg_idx_t rd_num;
    core_pkg::reg_idx_t sh_amount;
    logic [15:0]        imm;
    logic               commit_valid;
    core_pkg::reg_idx_t commit_num;
    core_pkg::word_t    commit_data;
    logic               halted;

    row_t  rows[$];
    string names[$];
    int    checks;
    int    errors;
    int    cycles;
    int    cycle_limit;

    control_unit control_unit_i (
        .clk          (clk),
        .rst_b        (rst_b),
        .opcode       (opcode),
        .func         (func),
        .rs_num       (rs_num),
        .rt_num       (rt_num),
        .rd_num       (rd_num),
        .sh_amount    (sh_amount),
        .imm          (imm),
        .commit_valid (commit_valid),
        .commit_num   (commit_num),
        .commit_data  (commit_data),
        .halted       (halted)
    );

    // 8 ns clock
    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    // watchdog on the number of cycles
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("run timed out after %0d cycles", cycles);
            $display("TESTS FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] sign_ext(input logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic push_row(input string name, input row_t r);
        rows.push_back(r);
        names.push_back(name);
    endtask

    // I-type with rt as destination
    task automatic imm_op(input string name, input logic [5:0] opc, input logic [4:0] rs,
                          input logic [4:0] rt, input logic [15:0] iv, input logic ev,
                          input logic [31:0] ed, input logic eh);
        row_t r;
        r = '{1'b0, opc, 6'(isa_pkg::FN_ADD), rs, rt, 5'd0, 5'd0, iv, ev, rt, ed, eh};
        push_row(name, r);
    endtask

    // R-type with rd as destination
    task automatic reg_op(input string name, input logic [5:0] fn, input logic [4:0] rs,
                          input logic [4:0] rt, input logic [4:0] rd, input logic [4:0] sh,
                          input logic ev, input logic [31:0] ed, input logic eh);
        row_t r;
        r = '{1'b0, 6'(isa_pkg::OPC_RTYPE), fn, rs, rt, rd, sh, 16'h0, ev, rd, ed, eh};
        push_row(name, r);
    endtask

    task automatic reset_step(input string name);
        row_t r;
        r = '0;
        r.rst = 1'b1;
        push_row(name, r);
    endtask

    task automatic build_table();
        logic [15:0] ra;
        logic [15:0] rb;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] neg;
        ra = 16'($urandom);
        rb = 16'($urandom);
        // nonzero low bits give sllv and srlv a real shift
        if (ra[4:0] == 5'd0) begin
            ra[0] = 1'b1;
        end
        // keep the operands apart so slt sees both outcomes
        if (rb == ra) begin
            rb = ra ^ 16'h0001;
        end
        a   = sign_ext(ra);
        b   = sign_ext(rb);
        neg = sign_ext(16'h8421);
        reset_step("reset");
        // operand loads and immediate forms
        imm_op("addiu_a", isa_pkg::OPC_ADDIU, 5'd0, 5'd1, ra, 1'b1, a, 1'b0);
        imm_op("addiu_b", isa_pkg::OPC_ADDIU, 5'd0, 5'd2, rb, 1'b1, b, 1'b0);
        imm_op("addiu_neg", isa_pkg::OPC_ADDIU, 5'd0, 5'd4, 16'h8421, 1'b1, neg, 1'b0);
        imm_op("addi_pos", isa_pkg::OPC_ADDI, 5'd0, 5'd6, 16'h7123, 1'b1, 32'h7123, 1'b0);
        imm_op("andi", isa_pkg::OPC_ANDI, 5'd4, 5'd7, 16'hf0f0, 1'b1, neg & 32'hf0f0, 1'b0);
        imm_op("xori", isa_pkg::OPC_XORI, 5'd4, 5'd8, 16'h80ff, 1'b1, neg ^ 32'h80ff, 1'b0);
        imm_op("lui", isa_pkg::OPC_LUI, 5'd0, 5'd10, 16'hbeef, 1'b1, 32'hbeef0000, 1'b0);
        // register arithmetic and logic
        reg_op("add", isa_pkg::FN_ADD, 5'd1, 5'd2, 5'd3, 5'd0, 1'b1, a + b, 1'b0);
        reg_op("addu", isa_pkg::FN_ADDU, 5'd2, 5'd4, 5'd3, 5'd0, 1'b1, b + neg, 1'b0);
        reg_op("sub", isa_pkg::FN_SUB, 5'd1, 5'd2, 5'd3, 5'd0, 1'b1, a - b, 1'b0);
        reg_op("subu", isa_pkg::FN_SUBU, 5'd2, 5'd1, 5'd3, 5'd0, 1'b1, b - a, 1'b0);
        reg_op("and", isa_pkg::FN_AND, 5'd1, 5'd2, 5'd3, 5'd0, 1'b1, a & b, 1'b0);
        reg_op("or", isa_pkg::FN_OR, 5'd1, 5'd2, 5'd3, 5'd0, 1'b1, a | b, 1'b0);
        reg_op("xor", isa_pkg::FN_XOR, 5'd1, 5'd2, 5'd3, 5'd0, 1'b1, a ^ b, 1'b0);
        reg_op("nor", isa_pkg::FN_NOR, 5'd1, 5'd2, 5'd3, 5'd0, 1'b1, ~(a | b), 1'b0);
        // signed compare both ways
        reg_op("slt_ab", isa_pkg::FN_SLT, 5'd1, 5'd2, 5'd3, 5'd0, 1'b1,
               32'($signed(a) < $signed(b)), 1'b0);
        reg_op("slt_ba", isa_pkg::FN_SLT, 5'd2, 5'd1, 5'd3, 5'd0, 1'b1,
               32'($signed(b) < $signed(a)), 1'b0);
        // negative below positive only when signed
        reg_op("slt_neg", isa_pkg::FN_SLT, 5'd4, 5'd6, 5'd3, 5'd0, 1'b1, 32'd1, 1'b0);
        reg_op("mult", isa_pkg::FN_MULT, 5'd1, 5'd2, 5'd5, 5'd0, 1'b1, a * b, 1'b0);
        reg_op("div", isa_pkg::FN_DIV, 5'd1, 5'd2, 5'd5, 5'd0, 1'b1,
               (b == 32'd0) ? 32'hffffffff : a / b, 1'b0);
        // rt of r0 means divide by zero
        reg_op("div_zero", isa_pkg::FN_DIV, 5'd1, 5'd0, 5'd5, 5'd0, 1'b1, 32'hffffffff, 1'b0);
        // shifts of a negative word
        reg_op("sll", isa_pkg::FN_SLL, 5'd0, 5'd4, 5'd11, 5'd4, 1'b1, neg << 4, 1'b0);
        reg_op("srl", isa_pkg::FN_SRL, 5'd0, 5'd4, 5'd11, 5'd4, 1'b1, neg >> 4, 1'b0);
        reg_op("sra", isa_pkg::FN_SRA, 5'd0, 5'd4, 5'd11, 5'd4, 1'b1,
               32'($signed(neg) >>> 4), 1'b0);
        reg_op("sllv", isa_pkg::FN_SLLV, 5'd1, 5'd4, 5'd11, 5'd0, 1'b1, neg << a[4:0], 1'b0);
        reg_op("srlv", isa_pkg::FN_SRLV, 5'd1, 5'd4, 5'd11, 5'd0, 1'b1, neg >> a[4:0], 1'b0);
        // r0 stays zero
        imm_op("write_r0", isa_pkg::OPC_ADDIU, 5'd0, 5'd0, 16'h1234, 1'b0, 32'h0, 1'b0);
        reg_op("read_r0", isa_pkg::FN_ADD, 5'd0, 5'd6, 5'd9, 5'd0, 1'b1, 32'h7123, 1'b0);
        // nothing commits after syscall
        reg_op("syscall", isa_pkg::FN_SYSCALL, 5'd0, 5'd0, 5'd0, 5'd0, 1'b0, 32'h0, 1'b1);
        imm_op("after_halt_i", isa_pkg::OPC_ADDIU, 5'd0, 5'd12, 16'h0005, 1'b0, 32'h0, 1'b1);
        reg_op("after_halt_r", isa_pkg::FN_ADD, 5'd1, 5'd2, 5'd9, 5'd0, 1'b0, 32'h0, 1'b1);
        // fresh reset followed by an unknown opcode
        reset_step("reset_again");
        imm_op("unknown_opc", 6'b111111, 5'd0, 5'd12, 16'h0005, 1'b0, 32'h0, 1'b1);
        imm_op("after_unknown", isa_pkg::OPC_ADDIU, 5'd0, 5'd12, 16'h0005, 1'b0, 32'h0, 1'b1);
    endtask

    // drive one row and check the commit port after its edge
    task automatic apply_row(input int i);
        row_t r;
        r = rows[i];
        if (r.rst) begin
            rst_b = 1'b0;
            repeat (2) @(posedge clk);
            #1;
            rst_b = 1'b1;
        end else begin
            opcode    = isa_pkg::opcode_e'(r.opc);
            func      = isa_pkg::func_e'(r.fn);
            rs_num    = r.rs;
            rt_num    = r.rt;
            rd_num    = r.rd;
            sh_amount = r.sh;
            imm       = r.imm;
            @(posedge clk);
            #1;
        end
        check_value({names[i], " commit_valid"}, 32'(r.exp_valid), 32'(commit_valid));
        check_value({names[i], " halted"}, 32'(r.exp_halted), 32'(halted));
        // payload only matters on a commit
        if (r.exp_valid) begin
            check_value({names[i], " commit_num"}, 32'(r.exp_num), 32'(commit_num));
            check_value({names[i], " commit_data"}, r.exp_data, commit_data);
        end
    endtask

    initial begin
        rst_b       = 1'b0;
        opcode      = isa_pkg::OPC_RTYPE;
        func        = isa_pkg::FN_ADD;
        rs_num      = '0;
        rt_num      = '0;
        rd_num      = '0;
        sh_amount   = '0;
        imm         = '0;
        checks      = 0;
        errors      = 0;
        cycles      = 0;
        cycle_limit = 0;
        void'($urandom(26));
        build_table();
        cycle_limit = 4 * rows.size() + 20;
        for (int i = 0; i < rows.size(); i++) begin
            apply_row(i);
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
